// ==== verilog/gui_pkg.sv ====
// shared widths, bus structs and tile addressing for the painter
// coordinates are 10 bits, so the raster must stay below 1024 in each axis
`default_nettype none

package gui_pkg;

    // tile size as a power of two, 32 x 16 pixels
    localparam int tile_cols_log2 = 5;
    localparam int tile_rows_log2 = 4;

    typedef logic [9:0] coord_t;
    typedef logic signed [9:0] delta_t;
    // red [8:6], green [5:3], blue [2:0]
    typedef logic [8:0] color_t;
    // {y / 16, x / 32}
    typedef logic [10:0] tile_addr_t;

    localparam int tile_count = 2 ** $bits(tile_addr_t);
    localparam color_t color_white = '1;

    // mouse button bits
    localparam int btn_left = 0;
    localparam int btn_right = 1;

    typedef struct packed {
        delta_t dx;
        delta_t dy;
        logic [2:0] buttons;
    } mouse_packet_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pointer_t;

    // syncs are active low
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic hsync;
        logic vsync;
        logic blank;
    } beam_t;

    typedef struct packed {
        tile_addr_t addr;
        color_t color;
    } paint_req_t;

    typedef struct packed {
        color_t color;
        logic hsync;
        logic vsync;
        logic blank;
    } video_out_t;

    // beam state held during reset: origin, syncs inactive, blanked
    localparam beam_t beam_reset = '{x: '0, y: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b1};

    // upper y bits select the tile row, upper x bits the tile column
    function automatic tile_addr_t to_tile_addr(coord_t x, coord_t y);
        return {y[$bits(coord_t)-1:tile_rows_log2], x[$bits(coord_t)-1:tile_cols_log2]};
    endfunction

endpackage

`default_nettype wire

// ==== verilog/video_timing.sv ====
// free running raster generator; porch and sync widths are in pixels and lines
// line and frame totals must fit in a 10-bit coordinate
`default_nettype none

module video_timing #(
    parameter gui_pkg::coord_t h_active = 10'd640,
    parameter gui_pkg::coord_t h_front = 10'd16,
    parameter gui_pkg::coord_t h_sync = 10'd96,
    parameter gui_pkg::coord_t h_back = 10'd48,
    parameter gui_pkg::coord_t v_active = 10'd480,
    parameter gui_pkg::coord_t v_front = 10'd10,
    parameter gui_pkg::coord_t v_sync = 10'd2,
    parameter gui_pkg::coord_t v_back = 10'd33
) (
    input  wire logic            clk_pixel,
    input  wire logic            reset,
    output gui_pkg::beam_t       beam
);
    import gui_pkg::*;

    localparam coord_t h_total = h_active + h_front + h_sync + h_back;
    localparam coord_t v_total = v_active + v_front + v_sync + v_back;
    localparam coord_t h_last = h_total - 10'd1;
    localparam coord_t v_last = v_total - 10'd1;

    // sync regions start right after the front porch
    localparam coord_t hs_start = h_active + h_front;
    localparam coord_t hs_end = hs_start + h_sync;
    localparam coord_t vs_start = v_active + v_front;
    localparam coord_t vs_end = vs_start + v_sync;

    coord_t x_next;
    coord_t y_next;

    always_comb
    begin
        x_next = beam.x + 10'd1;
        y_next = beam.y;
        if (beam.x == h_last)
        begin
            x_next = '0;
            // end of line steps the vertical counter
            if (beam.y == v_last)
                y_next = '0;
            else
                y_next = beam.y + 10'd1;
        end
    end

    // flags are decoded from the next count so they stay aligned with x and y
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            beam <= beam_reset;
        end
        else
        begin
            beam.x <= x_next;
            beam.y <= y_next;
            beam.hsync <= !(x_next >= hs_start && x_next < hs_end);
            beam.vsync <= !(y_next >= vs_start && y_next < vs_end);
            beam.blank <= (x_next >= h_active) || (y_next >= v_active);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pointer_tracker.sv ====
// accumulates relative mouse packets into a clamped absolute pointer
// paint requests are issued only once the tile map reports ready
`default_nettype none

module pointer_tracker #(
    parameter gui_pkg::coord_t h_active = 10'd640,
    parameter gui_pkg::coord_t v_active = 10'd480
) (
    input  wire logic                   clk_pixel,
    input  wire logic                   reset,
    input  wire logic                   ready,
    input  wire logic                   mouse_strobe,
    input  wire gui_pkg::mouse_packet_t mouse_packet,
    output gui_pkg::pointer_t           pointer,
    output gui_pkg::paint_req_t         paint_req,
    output logic                        paint_strobe
);
    import gui_pkg::*;

    localparam coord_t x_max = h_active - 10'd1;
    localparam coord_t y_max = v_active - 10'd1;

    pointer_t next_pointer;
    color_t paint_color;
    logic left_btn;
    logic right_btn;
    logic paint_hit;

    // two extra bits hold the sign and the carry of the sum
    function automatic coord_t clamp_axis(coord_t pos, delta_t step, coord_t limit);
        logic signed [11:0] sum;
        sum = $signed({2'b00, pos}) + $signed({{2{step[9]}}, step});
        if (sum < 12'sd0)
            return '0;
        else if (sum > $signed({2'b00, limit}))
            return limit;
        else
            return sum[9:0];
    endfunction

    assign next_pointer.x = clamp_axis(pointer.x, mouse_packet.dx, x_max);
    assign next_pointer.y = clamp_axis(pointer.y, mouse_packet.dy, y_max);

    assign left_btn = mouse_packet.buttons[btn_left];
    assign right_btn = mouse_packet.buttons[btn_right];
    assign paint_hit = mouse_strobe && ready && (left_btn || right_btn);

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            pointer <= '0;
            paint_strobe <= 1'b0;
            paint_color <= 9'd1;
        end
        else
        begin
            paint_strobe <= paint_hit;
            if (mouse_strobe)
                pointer <= next_pointer;
            // only left paints consume a colour, wrapping at 9 bits
            if (paint_hit && left_btn)
                paint_color <= paint_color + 9'd1;
        end
    end

    // request payload, qualified by paint_strobe
    always_ff @(posedge clk_pixel)
    begin
        if (mouse_strobe)
        begin
            paint_req.addr <= to_tile_addr(next_pointer.x, next_pointer.y);
            // left has priority when both buttons are held
            paint_req.color <= left_btn ? paint_color : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tile_map.sv ====
// tile colour memory, cleared to black by a sweep after reset
// paint writes are ignored until the sweep is done; read latency is one cycle
`default_nettype none

module tile_map (
    input  wire logic                clk_pixel,
    input  wire logic                reset,
    input  wire gui_pkg::beam_t      beam,
    input  wire gui_pkg::paint_req_t paint_req,
    input  wire logic                paint_strobe,
    output gui_pkg::color_t          tile_color,
    output gui_pkg::beam_t           beam_d,
    output logic                     ready
);
    import gui_pkg::*;

    typedef enum logic {
        sweeping,
        idle
    } clear_state_t;

    clear_state_t state;
    tile_addr_t sweep_addr;

    logic wr_en;
    tile_addr_t wr_addr;
    color_t wr_data;

    color_t mem [0:tile_count-1];

    assign ready = (state == idle);

    // clear FSM, one address per cycle
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            state <= sweeping;
            sweep_addr <= '0;
        end
        else if (state == sweeping)
        begin
            sweep_addr <= sweep_addr + 11'd1;
            if (sweep_addr == '1)
                state <= idle;
        end
    end

    // write port owned by the sweep until ready
    always_comb
    begin
        if (state == sweeping)
        begin
            wr_en = 1'b1;
            wr_addr = sweep_addr;
            wr_data = '0;
        end
        else
        begin
            wr_en = paint_strobe;
            wr_addr = paint_req.addr;
            wr_data = paint_req.color;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        tile_color <= mem[to_tile_addr(beam.x, beam.y)];
    end

    // beam copy stays in step with the read data
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
            beam_d <= beam_reset;
        else
            beam_d <= beam;
    end

endmodule

`default_nettype wire

// ==== verilog/pixel_mixer.sv ====
// final pipeline stage: crosshair over tile colour, forced black in blanking
// expects beam_d and tile_color to be aligned on the same cycle
`default_nettype none

module pixel_mixer (
    input  wire logic              clk_pixel,
    input  wire logic              reset,
    input  wire gui_pkg::beam_t    beam_d,
    input  wire gui_pkg::color_t   tile_color,
    input  wire gui_pkg::pointer_t pointer,
    output gui_pkg::video_out_t    video
);
    import gui_pkg::*;

    logic on_cross;
    color_t pixel_color;

    // full-screen lines through the pointer
    assign on_cross = (beam_d.x == pointer.x) || (beam_d.y == pointer.y);

    always_comb
    begin
        if (beam_d.blank)
            pixel_color = '0;
        else if (on_cross)
            pixel_color = color_white;
        else
            pixel_color = tile_color;
    end

    // colour and syncs leave together, two cycles behind the raw beam
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            video.color <= '0;
            video.hsync <= 1'b1;
            video.vsync <= 1'b1;
            video.blank <= 1'b1;
        end
        else
        begin
            video.color <= pixel_color;
            video.hsync <= beam_d.hsync;
            video.vsync <= beam_d.vsync;
            video.blank <= beam_d.blank;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gui_painter_top.sv ====
// mouse tile painter on a single pixel clock, default 640x480 timing
// mouse packets arrive decoded as one-cycle strobes; video is 9-bit RGB
`default_nettype none

module gui_painter_top #(
    parameter gui_pkg::coord_t h_active = 10'd640,
    parameter gui_pkg::coord_t h_front = 10'd16,
    parameter gui_pkg::coord_t h_sync = 10'd96,
    parameter gui_pkg::coord_t h_back = 10'd48,
    parameter gui_pkg::coord_t v_active = 10'd480,
    parameter gui_pkg::coord_t v_front = 10'd10,
    parameter gui_pkg::coord_t v_sync = 10'd2,
    parameter gui_pkg::coord_t v_back = 10'd33
) (
    input  wire logic                   clk_pixel,
    input  wire logic                   reset,
    input  wire logic                   mouse_strobe,
    input  wire gui_pkg::mouse_packet_t mouse_packet,
    output gui_pkg::video_out_t         video,
    output gui_pkg::pointer_t           pointer,
    output logic                        ready
);
    import gui_pkg::*;

    beam_t beam;
    beam_t beam_d;
    paint_req_t paint_req;
    logic paint_strobe;
    color_t tile_color;

    video_timing #(
        .h_active(h_active),
        .h_front(h_front),
        .h_sync(h_sync),
        .h_back(h_back),
        .v_active(v_active),
        .v_front(v_front),
        .v_sync(v_sync),
        .v_back(v_back)
    ) u_video_timing (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .beam(beam)
    );

    // side path from the mouse into the tile memory
    pointer_tracker #(
        .h_active(h_active),
        .v_active(v_active)
    ) u_pointer_tracker (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .ready(ready),
        .mouse_strobe(mouse_strobe),
        .mouse_packet(mouse_packet),
        .pointer(pointer),
        .paint_req(paint_req),
        .paint_strobe(paint_strobe)
    );

    tile_map u_tile_map (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .beam(beam),
        .paint_req(paint_req),
        .paint_strobe(paint_strobe),
        .tile_color(tile_color),
        .beam_d(beam_d),
        .ready(ready)
    );

    pixel_mixer u_pixel_mixer (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .beam_d(beam_d),
        .tile_color(tile_color),
        .pointer(pointer),
        .video(video)
    );

endmodule

`default_nettype wire

// ==== testbench/gui_painter_asserts.sv ====
// concurrent checks on the painter top level, attached by bind
// reads internal beam and paint strobe nets of the top module
`default_nettype none

module gui_painter_asserts #(
    parameter gui_pkg::coord_t h_active = 10'd640,
    parameter gui_pkg::coord_t v_active = 10'd480
) (
    input wire logic                clk_pixel,
    input wire logic                reset,
    input wire logic                ready,
    input wire logic                paint_strobe,
    input wire gui_pkg::beam_t      beam,
    input wire gui_pkg::beam_t      beam_d,
    input wire gui_pkg::pointer_t   pointer,
    input wire gui_pkg::video_out_t video
);
    import gui_pkg::*;

    // one cycle into reset the sweep has not finished and video is blanked
    reset_state: assert property (@(posedge clk_pixel)
        reset |=> !ready && video.blank && video.hsync && video.vsync)
        else $error("ready or blank wrong after reset");

    // once the sweep is done ready holds until the next reset
    ready_holds: assert property (@(posedge clk_pixel) disable iff (reset)
        ready |=> ready)
        else $error("ready dropped without reset");

    // packets are spaced apart, so a paint never lasts two cycles
    single_paint: assert property (@(posedge clk_pixel) disable iff (reset)
        paint_strobe |=> !paint_strobe)
        else $error("paint strobe held for two cycles");

    // the first cycle after reset still carries the reset beam
    blank_bounds: assert property (@(posedge clk_pixel) disable iff (reset)
        !$past(reset) |-> beam.blank == (beam.x >= h_active || beam.y >= v_active))
        else $error("blank does not match beam bounds");

    crosshair: assert property (@(posedge clk_pixel) disable iff (reset)
        (!beam_d.blank && (beam_d.x == pointer.x || beam_d.y == pointer.y))
        |=> video.color == color_white)
        else $error("crosshair pixel not white");

endmodule

bind gui_painter_top gui_painter_asserts #(
    .h_active(h_active),
    .v_active(v_active)
) u_asserts (
    .clk_pixel(clk_pixel),
    .reset(reset),
    .ready(ready),
    .paint_strobe(paint_strobe),
    .beam(beam),
    .beam_d(beam_d),
    .pointer(pointer),
    .video(video)
);

`default_nettype wire

// ==== testbench/tb_gui_painter.sv ====
// painter testbench on a 128x64 raster with 4x4 tiles
// beam position is rebuilt from the sync edges seen at the video port
`default_nettype none

module tb_gui_painter;
    import gui_pkg::*;

    localparam int h_tot = 144;
    localparam int v_tot = 70;

    logic clk_pixel = 1'b0;
    logic reset = 1'b1;
    logic mouse_strobe = 1'b0;
    mouse_packet_t mouse_packet = '0;
    video_out_t video;
    pointer_t pointer;
    logic ready;

    // reference model
    int exp_x = 0;
    int exp_y = 0;
    int paint_cnt = 1;
    color_t tiles [0:3][0:3];
    // paints count only after the clear sweep has been seen to finish
    logic swept = 1'b0;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    integer seed = 32'hc9cf;

    // raster tracking from the ports
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    logic hs_seen = 1'b0;
    logic vs_seen = 1'b0;
    logic pix_en = 1'b0;
    int vx = 0;
    int vy = 0;
    int hs_low = 0;
    int hs_per = 0;
    int vs_per = 0;
    int frames_seen = 0;

    gui_painter_top #(
        .h_active(10'd128), .h_front(10'd4), .h_sync(10'd8), .h_back(10'd4),
        .v_active(10'd64), .v_front(10'd2), .v_sync(10'd2), .v_back(10'd2)
    ) UUT (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .mouse_strobe(mouse_strobe),
        .mouse_packet(mouse_packet),
        .video(video),
        .pointer(pointer),
        .ready(ready)
    );

    always #10 clk_pixel = !clk_pixel;

    function automatic color_t expected_pixel(int x, int y);
        if (x >= 128 || y >= 64)
            return '0;
        if (x == exp_x || y == exp_y)
            return color_white;
        return tiles[y / 16][x / 32];
    endfunction

    // all port checks run here, half a cycle after the outputs change
    always @(negedge clk_pixel)
    begin
        if (!reset)
        begin
            vx = (vx == h_tot - 1) ? 0 : vx + 1;
            if (vx == 0)
                vy = (vy == v_tot - 1) ? 0 : vy + 1;
            hs_per++;
            vs_per++;
            if (prev_hs && !video.hsync)
            begin
                if (hs_seen)
                    assert (hs_per == h_tot) else begin
                        $display("mismatch at %0t: line period %0d", $time, hs_per);
                        errors++;
                    end
                vx = 132;
                hs_seen = 1'b1;
                hs_per = 0;
                hs_low = 0;
            end
            if (!prev_hs && video.hsync && hs_seen)
                assert (hs_low == 8) else begin
                    $display("mismatch at %0t: hsync width %0d", $time, hs_low);
                    errors++;
                end
            if (!video.hsync)
                hs_low++;
            if (prev_vs && !video.vsync)
            begin
                if (vs_seen)
                    assert (vs_per == h_tot * v_tot) else begin
                        $display("mismatch at %0t: frame period %0d", $time, vs_per);
                        errors++;
                    end
                vy = 66;
                vs_seen = 1'b1;
                vs_per = 0;
                frames_seen++;
            end
            if (hs_seen && vs_seen)
            begin
                assert (video.blank == (vx >= 128 || vy >= 64)) else begin
                    $display("mismatch at %0t: blank %b at %0d,%0d", $time, video.blank, vx, vy);
                    errors++;
                end
                if (pix_en)
                    assert (video.color == expected_pixel(vx, vy)) else begin
                        $display("mismatch at %0t: pixel %0d,%0d is %h, expected %h",
                            $time, vx, vy, video.color, expected_pixel(vx, vy));
                        errors++;
                    end
            end
            prev_hs = video.hsync;
            prev_vs = video.vsync;
        end
    end

    task automatic give_up(string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic report_test(string name, int err_before);
        tests_run++;
        if (errors != err_before)
            tests_failed++;
        $display("test %s: %s (%0d errors)", name,
            (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready)
        begin
            @(negedge clk_pixel);
            n++;
            if (n > 3000)
                give_up("ready after the clear sweep");
        end
    endtask

    task automatic wait_frame();
        int f0;
        int n;
        f0 = frames_seen;
        n = 0;
        while (frames_seen == f0)
        begin
            @(posedge clk_pixel);
            n++;
            if (n > 2 * h_tot * v_tot)
                give_up("a vsync edge");
        end
    endtask

    // checks every pixel over one full frame
    task automatic check_frame();
        wait_frame();
        pix_en <= 1'b1;
        wait_frame();
        pix_en <= 1'b0;
    endtask

    task automatic send_packet(int dx, int dy, logic [2:0] buttons);
        @(posedge clk_pixel);
        mouse_strobe <= 1'b1;
        mouse_packet <= '{dx: delta_t'(dx), dy: delta_t'(dy), buttons: buttons};
        @(negedge clk_pixel);
        exp_x = (exp_x + dx < 0) ? 0 : (exp_x + dx > 127) ? 127 : exp_x + dx;
        exp_y = (exp_y + dy < 0) ? 0 : (exp_y + dy > 63) ? 63 : exp_y + dy;
        if (swept && (buttons[0] || buttons[1]))
        begin
            tiles[exp_y / 16][exp_x / 32] = buttons[0] ? color_t'(paint_cnt) : '0;
            if (buttons[0])
                paint_cnt = (paint_cnt + 1) % 512;
        end
        @(posedge clk_pixel);
        mouse_strobe <= 1'b0;
        @(negedge clk_pixel);
        assert (pointer.x == exp_x && pointer.y == exp_y) else begin
            $display("mismatch at %0t: pointer %0d,%0d expected %0d,%0d",
                $time, pointer.x, pointer.y, exp_x, exp_y);
            errors++;
        end
        // leave room for the tile write
        @(posedge clk_pixel);
    endtask

    task automatic move_to(int x, int y, logic [2:0] buttons);
        send_packet(x - exp_x, y - exp_y, buttons);
    endtask

    initial
    begin
        int e;
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
                tiles[r][c] = '0;

        e = errors;
        repeat (2) @(posedge clk_pixel);
        reset <= 1'b0;
        assert (video.blank && video.hsync && video.vsync && !ready) else begin
            $display("mismatch at %0t: outputs not in reset state", $time);
            errors++;
        end
        // left click while the sweep is still running must be dropped
        send_packet(40, 20, 3'b001);
        wait_ready();
        swept = 1'b1;
        check_frame();
        report_test("reset and clear", e);

        e = errors;
        repeat (2) wait_frame();
        report_test("timing", e);

        e = errors;
        for (int i = 0; i < 20; i++)
            send_packet($random(seed) % 200, $random(seed) % 100, 3'b000);
        send_packet(-500, -500, 3'b000);
        send_packet(500, 500, 3'b000);
        send_packet(-300, 7, 3'b000);
        report_test("pointer tracking", e);

        e = errors;
        check_frame();
        report_test("crosshair", e);

        e = errors;
        move_to(5, 5, 3'b001);
        move_to(40, 20, 3'b001);
        move_to(100, 50, 3'b001);
        move_to(5, 5, 3'b010);
        move_to(70, 35, 3'b011);
        check_frame();
        report_test("painting", e);

        // the early click must not have shifted the paint colours on screen
        e = errors;
        check_frame();
        report_test("dropped early paint", e);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/gui_pkg.sv
verilog/video_timing.sv
verilog/pointer_tracker.sv
verilog/tile_map.sv
verilog/pixel_mixer.sv
verilog/gui_painter_top.sv
testbench/gui_painter_asserts.sv
testbench/tb_gui_painter.sv

// ==== Makefile ====
SRCS := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_gui_painter: $(SRCS) build.f
	verilator --binary --timing --assert -sv -Wno-fatal \
		--top-module tb_gui_painter -Mdir obj_dir -f build.f

run: obj_dir/Vtb_gui_painter
	./obj_dir/Vtb_gui_painter | tee sim.log
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
